/* logic/udp_echo_pkg.sv */
// UDP echo shared definitions
// Header field widths, payload byte type and filter states

package udp_echo_pkg;

    // Header field sizes, TTL and checksum are left to the downstream stack
    localparam int IP_ADDR_W = 32;
    localparam int PORT_W    = 16;
    localparam int LEN_W     = 16;
    localparam int BYTE_W    = 8;

    typedef logic [IP_ADDR_W-1:0] ip_addr_t;
    typedef logic [PORT_W-1:0]    udp_port_t;
    typedef logic [LEN_W-1:0]     udp_len_t;
    typedef logic [BYTE_W-1:0]    byte_t;

    // Per-frame decision of the receive filter
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } filter_state_t;

    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

endpackage

/* logic/udp_hdr_if.sv */
// UDP header transfer
// One header per handshake, addresses and ports only

interface udp_hdr_if;
    import udp_echo_pkg::*;

    logic      valid;
    logic      ready;
    ip_addr_t  peer_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;

    modport source (
        output valid, peer_ip, src_port, dst_port, length,
        input  ready
    );
    modport sink (
        input  valid, peer_ip, src_port, dst_port, length,
        output ready
    );
    // Passive view, observes fields and handshake
    modport monitor (input valid, ready, peer_ip, src_port, dst_port, length);

endinterface

/* logic/byte_stream_if.sv */
// Byte stream with end-of-frame marker
// Valid/ready handshake, one byte per beat

interface byte_stream_if;
    import udp_echo_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;

    modport source (
        output data, valid, last,
        input  ready
    );
    modport sink (
        input  data, valid, last,
        output ready
    );
    modport monitor (input data, valid, ready, last);

endinterface

/* logic/echo_filter_fsm.sv */
// UDP echo receive filter
// Accepts echo-port frames into the FIFO and discards all others

module echo_filter_fsm #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  logic          clk,
    input  logic          rst,
    udp_hdr_if.sink       rx_hdr,
    byte_stream_if.sink   rx_pay,
    byte_stream_if.source fifo_in,
    input  logic          reply_busy,
    output logic          reply_load
);
    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;
    logic          port_match;
    logic          hdr_ready;
    logic          pay_ready;
    logic          fwd_valid;

    assign port_match = rx_hdr.dst_port == ECHO_PORT;

    always_comb begin
        state_next = state;
        hdr_ready  = 1'b0;
        pay_ready  = 1'b0;
        fwd_valid  = 1'b0;
        reply_load = 1'b0;
        case (state)
            IDLE: begin
                if (rx_hdr.valid) begin
                    if (!port_match) begin
                        hdr_ready  = 1'b1;
                        state_next = DROP;
                    end else if (!reply_busy) begin
                        // Previous reply header has gone out
                        hdr_ready  = 1'b1;
                        reply_load = 1'b1;
                        state_next = FORWARD;
                    end
                end
            end
            FORWARD: begin
                pay_ready = fifo_in.ready;
                fwd_valid = rx_pay.valid;
                if (rx_pay.valid && fifo_in.ready && rx_pay.last) begin
                    state_next = IDLE;
                end
            end
            DROP: begin
                pay_ready = 1'b1;
                if (rx_pay.valid && rx_pay.last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign rx_hdr.ready  = hdr_ready;
    assign rx_pay.ready  = pay_ready;
    assign fifo_in.valid = fwd_valid;
    assign fifo_in.data  = rx_pay.data;
    assign fifo_in.last  = rx_pay.last;

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst) state inside {IDLE, FORWARD, DROP}
    );

endmodule

/* logic/payload_fifo.sv */
// Payload FIFO
// Circular buffer of bytes with their last flags

module payload_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic          clk,
    input  logic          rst,
    byte_stream_if.sink   fifo_in,
    byte_stream_if.source tx_pay
);
    import udp_echo_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int WORD_W = $bits(byte_t) + 1;

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic [ADDR_W:0]   fill;
    logic              full;
    logic              empty;
    logic              wr_en;
    logic              rd_en;

    // Pointers carry one wrap bit so fill can reach the full depth
    assign fill  = wr_ptr - rd_ptr;
    assign full  = fill[ADDR_W];
    assign empty = fill == '0;

    assign wr_en = fifo_in.valid && fifo_in.ready;
    assign rd_en = tx_pay.valid && tx_pay.ready;

    assign fifo_in.ready = !full;
    assign tx_pay.valid  = !empty;
    assign {tx_pay.last, tx_pay.data} = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {fifo_in.last, fifo_in.data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // A write into a full buffer would overwrite the byte held at the output
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        tx_pay.valid && !tx_pay.ready |=> tx_pay.valid
            && $stable({tx_pay.last, tx_pay.data})
    );

endmodule

/* logic/echo_reply_tx.sv */
// Echo reply stage
// Holds the turned-around UDP header and shows each frame's first byte on the LEDs

module echo_reply_tx (
    input  logic                 clk,
    input  logic                 rst,
    udp_hdr_if.monitor           rx_hdr,
    input  logic                 reply_load,
    output logic                 reply_busy,
    udp_hdr_if.source            tx_hdr,
    byte_stream_if.monitor       tx_pay,
    output udp_echo_pkg::byte_t  led
);
    import udp_echo_pkg::*;

    ip_addr_t  peer_ip_q;
    udp_port_t src_port_q;
    udp_port_t dst_port_q;
    udp_len_t  length_q;
    logic      hdr_valid;
    logic      first_beat;

    // Ports swap, source IP becomes the destination
    always_ff @(posedge clk) begin
        if (reply_load) begin
            peer_ip_q  <= rx_hdr.peer_ip;
            src_port_q <= rx_hdr.dst_port;
            dst_port_q <= rx_hdr.src_port;
            length_q   <= rx_hdr.length;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid <= 1'b0;
        end else if (reply_load) begin
            hdr_valid <= 1'b1;
        end else if (tx_hdr.ready) begin
            hdr_valid <= 1'b0;
        end
    end

    assign tx_hdr.valid    = hdr_valid;
    assign tx_hdr.peer_ip  = peer_ip_q;
    assign tx_hdr.src_port = src_port_q;
    assign tx_hdr.dst_port = dst_port_q;
    assign tx_hdr.length   = length_q;
    assign reply_busy      = hdr_valid;

    // First beat after a last beat starts a new frame
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (tx_pay.valid && tx_pay.ready) begin
            if (first_beat) begin
                led <= tx_pay.data;
            end
            first_beat <= tx_pay.last;
        end
    end

    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr.valid && !tx_hdr.ready |=> tx_hdr.valid
            && $stable({tx_hdr.peer_ip, tx_hdr.src_port, tx_hdr.dst_port, tx_hdr.length})
    );

endmodule

/* logic/udp_echo_core.sv */
// UDP echo core
// Turns echo-port frames around and discards traffic for other ports

module udp_echo_core #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT  = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                      FIFO_DEPTH = 64
) (
    input  logic                      clk,
    input  logic                      rst,

    // Incoming UDP header
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t    rx_src_ip,
    input  udp_echo_pkg::udp_port_t   rx_src_port,
    input  udp_echo_pkg::udp_port_t   rx_dst_port,
    input  udp_echo_pkg::udp_len_t    rx_length,

    // Incoming payload
    input  udp_echo_pkg::byte_t       rx_data,
    input  logic                      rx_valid,
    output logic                      rx_ready,
    input  logic                      rx_last,

    // Reply header
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t    tx_dst_ip,
    output udp_echo_pkg::udp_port_t   tx_src_port,
    output udp_echo_pkg::udp_port_t   tx_dst_port,
    output udp_echo_pkg::udp_len_t    tx_length,

    // Outgoing payload
    output udp_echo_pkg::byte_t       tx_data,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    output logic                      tx_last,

    output udp_echo_pkg::byte_t       led
);

    udp_hdr_if     rx_hdr ();
    udp_hdr_if     tx_hdr ();
    byte_stream_if rx_pay ();
    byte_stream_if fifo_in ();
    byte_stream_if tx_pay ();

    logic reply_load;
    logic reply_busy;

    assign rx_hdr.valid    = rx_hdr_valid;
    assign rx_hdr.peer_ip  = rx_src_ip;
    assign rx_hdr.src_port = rx_src_port;
    assign rx_hdr.dst_port = rx_dst_port;
    assign rx_hdr.length   = rx_length;
    assign rx_hdr_ready    = rx_hdr.ready;

    assign rx_pay.data  = rx_data;
    assign rx_pay.valid = rx_valid;
    assign rx_pay.last  = rx_last;
    assign rx_ready     = rx_pay.ready;

    assign tx_hdr_valid = tx_hdr.valid;
    assign tx_hdr.ready = tx_hdr_ready;
    assign tx_dst_ip    = tx_hdr.peer_ip;
    assign tx_src_port  = tx_hdr.src_port;
    assign tx_dst_port  = tx_hdr.dst_port;
    assign tx_length    = tx_hdr.length;

    assign tx_data      = tx_pay.data;
    assign tx_valid     = tx_pay.valid;
    assign tx_last      = tx_pay.last;
    assign tx_pay.ready = tx_ready;

    echo_filter_fsm #(
        .ECHO_PORT (ECHO_PORT)
    ) u_filter (
        .clk        (clk),
        .rst        (rst),
        .rx_hdr     (rx_hdr),
        .rx_pay     (rx_pay),
        .fifo_in    (fifo_in),
        .reply_busy (reply_busy),
        .reply_load (reply_load)
    );

    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .fifo_in (fifo_in),
        .tx_pay  (tx_pay)
    );

    echo_reply_tx u_reply (
        .clk        (clk),
        .rst        (rst),
        .rx_hdr     (rx_hdr),
        .reply_load (reply_load),
        .reply_busy (reply_busy),
        .tx_hdr     (tx_hdr),
        .tx_pay     (tx_pay),
        .led        (led)
    );

endmodule

/* sim/tb_udp_echo_core.sv */
// UDP echo core testbench
// Random frames from an xorshift source, checked against a queue of expected replies

module tb_udp_echo_core;
    timeunit 1ns;
    timeprecision 1ps;
    import udp_echo_pkg::*;

    localparam int NUM_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 20 * 8;

    logic        clk, rst, rx_hdr_valid, rx_hdr_ready, rx_valid, rx_ready, rx_last;
    logic        tx_hdr_valid, tx_hdr_ready, tx_valid, tx_ready, tx_last;
    ip_addr_t    rx_src_ip, tx_dst_ip;
    udp_port_t   rx_src_port, rx_dst_port, tx_src_port, tx_dst_port;
    udp_len_t    rx_length, tx_length;
    byte_t       rx_data, tx_data, led, led_exp;
    logic        first_exp, started, stall;
    logic [31:0] frame_rng, bp_rng;
    // Expected reply headers {dst_ip, src_port, dst_port, length} and beats {last, data}
    logic [79:0] exp_hdr_q[$];
    logic [8:0]  exp_byte_q[$];
    int          stall_len, full_cycles, frames_sent, errors;
    int          cycles = 0;

    udp_echo_core #(
        .ECHO_PORT  (DEFAULT_ECHO_PORT),
        .FIFO_DEPTH (64)
    ) UUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // One frame, header first, then 1 to 16 payload bytes
    task automatic send_frame();
        ip_addr_t  ip;
        udp_port_t sport;
        udp_port_t dport;
        int        n;
        logic      hs;
        frame_rng = xorshift(frame_rng);
        ip = frame_rng;
        frame_rng = xorshift(frame_rng);
        sport = frame_rng[15:0];
        dport = frame_rng[16] ? DEFAULT_ECHO_PORT : frame_rng[31:16];
        n = int'(frame_rng[11:8]) + 1;
        if (dport == DEFAULT_ECHO_PORT) begin
            exp_hdr_q.push_back({ip, dport, sport, udp_len_t'(8 + n)});
        end
        rx_hdr_valid = 1'b1;
        rx_src_ip    = ip;
        rx_src_port  = sport;
        rx_dst_port  = dport;
        rx_length    = udp_len_t'(8 + n);
        hs = 1'b0;
        while (!hs) begin
            #1;
            hs = rx_hdr_ready;
            @(negedge clk);
        end
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            frame_rng = xorshift(frame_rng);
            rx_valid = 1'b1;
            rx_data  = frame_rng[7:0];
            rx_last  = i == n - 1;
            if (dport == DEFAULT_ECHO_PORT) begin
                exp_byte_q.push_back({rx_last, rx_data});
            end
            hs = 1'b0;
            while (!hs) begin
                #1;
                hs = rx_ready;
                @(negedge clk);
            end
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Tx side: random back-pressure, one long stall, reply and LED checks
    initial begin
        logic [79:0] hdr;
        logic [8:0]  beat;
        wait (started);
        forever begin
            @(negedge clk);
            bp_rng       = xorshift(bp_rng);
            tx_ready     = !stall && bp_rng[1:0] != 2'b00;
            tx_hdr_ready = bp_rng[2];
            #1;
            compare_value("led", 32'(led_exp), 32'(led));
            if (stall) begin
                stall_len++;
                if (rx_valid && !rx_ready) full_cycles++;
                if (full_cycles >= 16 || stall_len >= 1000) stall = 1'b0;
            end else if (stall_len == 0 && frames_sent >= 5) begin
                stall = 1'b1;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    errors++;
                    $display("Reply header at %0t has no matching request", $time);
                end else begin
                    hdr = exp_hdr_q.pop_front();
                    compare_value("tx_dst_ip", hdr[79:48], tx_dst_ip);
                    compare_value("tx_src_port", 32'(hdr[47:32]), 32'(tx_src_port));
                    compare_value("tx_dst_port", 32'(hdr[31:16]), 32'(tx_dst_port));
                    compare_value("tx_length", 32'(hdr[15:0]), 32'(tx_length));
                end
            end
            if (tx_valid && tx_ready) begin
                if (exp_byte_q.size() == 0) begin
                    errors++;
                    $display("Payload byte at %0t was never sent to the echo port", $time);
                end else begin
                    beat = exp_byte_q.pop_front();
                    compare_value("tx_data", 32'(beat[7:0]), 32'(tx_data));
                    compare_value("tx_last", 32'(beat[8]), 32'(tx_last));
                    if (first_exp) led_exp = beat[7:0];
                    first_exp = beat[8];
                end
            end
        end
    end

    initial begin
        int drain;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_ready     = 1'b0;
        frame_rng    = 32'h92a6;
        // Back-pressure stream from the inverted seed
        bp_rng       = ~32'h92a6;
        led_exp      = '0;
        first_exp    = 1'b1;
        started      = 1'b0;
        stall        = 1'b0;
        stall_len    = 0;
        full_cycles  = 0;
        frames_sent  = 0;
        errors       = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        compare_value("tx_hdr_valid", 32'd0, 32'(tx_hdr_valid));
        compare_value("tx_valid", 32'd0, 32'(tx_valid));
        compare_value("rx_hdr_ready", 32'd0, 32'(rx_hdr_ready));
        compare_value("led", 32'd0, 32'(led));
        started = 1'b1;
        @(negedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
            frames_sent++;
        end
        drain = 0;
        while ((exp_hdr_q.size() != 0 || exp_byte_q.size() != 0) && drain < 500) begin
            @(negedge clk);
            drain++;
        end
        // A few more cycles to catch stray output
        repeat (4) @(negedge clk);
        if (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0) begin
            errors++;
            $display("Leftover in model: %0d headers and %0d bytes never echoed",
                     exp_hdr_q.size(), exp_byte_q.size());
        end
        if (full_cycles == 0) begin
            errors++;
            $display("The tx stall never filled the FIFO, rx_ready stayed high");
        end
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* udp_echo_core.f */
logic/udp_echo_pkg.sv
logic/udp_hdr_if.sv
logic/byte_stream_if.sv
logic/echo_filter_fsm.sv
logic/payload_fifo.sv
logic/echo_reply_tx.sv
logic/udp_echo_core.sv
sim/tb_udp_echo_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_udp_echo_core \
    -f udp_echo_core.f -o tb_udp_echo_core > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_udp_echo_core > sim.log 2>&1 || echo "TEST FAIL" >> sim.log
grep -q "TEST PASS" sim.log || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
